// File: Makefile
# Verilator build and run of the CPU debug testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_debug
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
DEPTH     ?= 8
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# A failing check ends with $fatal, so the run returns a failing status
sim:
	$(VERILATOR) $(VFLAGS) -GQUEUE_DEPTH=$(DEPTH) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/cpu_debug_pkg.sv
package cpu_debug_pkg;

	//////////////////////////////
	// Data path widths
	//////////////////////////////
	localparam int DATA_W     = 16;
	localparam int REG_ADDR_W = 4;
	localparam int NUM_REGS   = 16;
	localparam int DEBUG_W    = NUM_REGS * DATA_W;

	typedef logic [DATA_W-1:0]     reg_value_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Op in [15:12], rd in [11:8], rs in [7:4], rt in [3:0] and LI immediate in [7:0]
	typedef enum logic [3:0] {
		OP_NOP = 4'h0,
		OP_LI  = 4'h1,
		OP_ADD = 4'h2,
		OP_SUB = 4'h3,
		OP_AND = 4'h4,
		OP_OR  = 4'h5,
		OP_XOR = 4'h6,
		OP_MOV = 4'h7
	} opcode_t;

	//////////////////////////////
	// LED view selector codes
	//////////////////////////////
	typedef logic [7:0] view_sel_t;

	localparam view_sel_t VIEW_STATUS      = 8'h00;
	localparam view_sel_t VIEW_FRONT_PC    = 8'h0F;
	localparam view_sel_t VIEW_FRONT_INST  = 8'h10;
	localparam view_sel_t VIEW_EXE_PC      = 8'h16;
	localparam view_sel_t VIEW_EXE_INST    = 8'h17;
	localparam view_sel_t VIEW_EXE_CTRL    = 8'h18;
	localparam view_sel_t VIEW_ALU_OP1     = 8'h19;
	localparam view_sel_t VIEW_ALU_OP2     = 8'h1A;
	localparam view_sel_t VIEW_ALU_RES     = 8'h1B;
	localparam view_sel_t VIEW_WB_DATA     = 8'h20;
	// Register k sits at VIEW_REG_HI - k
	localparam view_sel_t VIEW_REG_LO      = 8'h30;
	localparam view_sel_t VIEW_REG_HI      = 8'h3F;
	localparam view_sel_t VIEW_QUEUE_PTR   = 8'h40;
	localparam view_sel_t VIEW_QUEUE_FRONT = 8'h41;

endpackage

// File: hdl/cpu_debug_top.sv
`timescale 1ns/10ps

module cpu_debug_top import cpu_debug_pkg::*; #(
	parameter  int QUEUE_DEPTH = 8,
	localparam int PTR_W       = $clog2(QUEUE_DEPTH)
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] sw,
	input  logic        push,
	input  reg_value_t  push_inst,
	input  logic        hold,
	output logic [15:0] led_data,
	output logic        full,
	output logic        busy
);

	// Queue to execute
	reg_value_t         front_inst;
	reg_value_t         front_pc;
	logic [PTR_W-1:0]   front_ptr;
	logic [PTR_W-1:0]   tail_ptr;
	logic               empty;
	logic               pop;

	// Register file ports
	reg_addr_t          rd_addr1;
	reg_addr_t          rd_addr2;
	reg_value_t         rd_data1;
	reg_value_t         rd_data2;
	logic               wr_en;
	reg_addr_t          wr_addr;
	reg_value_t         wr_data;
	logic [DEBUG_W-1:0] reg_debug;

	// Execute registers for debug
	reg_value_t         exe_pc;
	reg_value_t         exe_inst;
	reg_value_t         alu_op1;
	reg_value_t         alu_op2;
	reg_value_t         alu_res;
	logic               alu_flag;

	fetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_fetch_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (push),
		.push_inst  (push_inst),
		.pop        (pop),
		.front_inst (front_inst),
		.front_pc   (front_pc),
		.front_ptr  (front_ptr),
		.tail_ptr   (tail_ptr),
		.empty      (empty),
		.full       (full)
	);

	exec_stage u_exec_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.hold       (hold),
		.empty      (empty),
		.front_inst (front_inst),
		.front_pc   (front_pc),
		.rd_data1   (rd_data1),
		.rd_data2   (rd_data2),
		.pop        (pop),
		.rd_addr1   (rd_addr1),
		.rd_addr2   (rd_addr2),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.exe_pc     (exe_pc),
		.exe_inst   (exe_inst),
		.alu_op1    (alu_op1),
		.alu_op2    (alu_op2),
		.alu_res    (alu_res),
		.alu_flag   (alu_flag),
		.busy       (busy)
	);

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr1  (rd_addr1),
		.rd_addr2  (rd_addr2),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_data1  (rd_data1),
		.rd_data2  (rd_data2),
		.reg_debug (reg_debug)
	);

	led_ctrl #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_led_ctrl (
		.sw         (sw),
		.front_ptr  (front_ptr),
		.tail_ptr   (tail_ptr),
		.front_inst (front_inst),
		.front_pc   (front_pc),
		.exe_pc     (exe_pc),
		.exe_inst   (exe_inst),
		.alu_op1    (alu_op1),
		.alu_op2    (alu_op2),
		.alu_res    (alu_res),
		.alu_flag   (alu_flag),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.hold       (hold),
		.empty      (empty),
		.full       (full),
		.busy       (busy),
		.reg_debug  (reg_debug),
		.led_data   (led_data)
	);

endmodule

// File: hdl/exec_stage.sv
`timescale 1ns/10ps

module exec_stage import cpu_debug_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       hold,
	input  logic       empty,
	input  reg_value_t front_inst,
	input  reg_value_t front_pc,
	input  reg_value_t rd_data1,
	input  reg_value_t rd_data2,
	output logic       pop,
	output reg_addr_t  rd_addr1,
	output reg_addr_t  rd_addr2,
	output logic       wr_en,
	output reg_addr_t  wr_addr,
	output reg_value_t wr_data,
	output reg_value_t exe_pc,
	output reg_value_t exe_inst,
	output reg_value_t alu_op1,
	output reg_value_t alu_op2,
	output reg_value_t alu_res,
	output logic       alu_flag,
	output logic       busy
);

	opcode_t    dec_op;
	reg_value_t fwd_op1;
	reg_value_t fwd_op2;
	reg_value_t op1_d;
	reg_value_t op2_d;
	reg_value_t res_d;
	logic       writes_d;

	assign pop  = ~empty & ~hold;
	assign busy = ~empty | wr_en;

	// Decode of the queue front
	assign dec_op   = opcode_t'(front_inst[15:12]);
	assign rd_addr1 = front_inst[7:4];
	assign rd_addr2 = front_inst[3:0];

	// Pending write has not reached the register file yet
	assign fwd_op1 = (wr_en && wr_addr == rd_addr1) ? wr_data : rd_data1;
	assign fwd_op2 = (wr_en && wr_addr == rd_addr2) ? wr_data : rd_data2;

	//////////////////////////////
	// ALU
	//////////////////////////////
	always_comb begin
		op1_d    = fwd_op1;
		op2_d    = fwd_op2;
		res_d    = '0;
		writes_d = 1'b1;
		case (dec_op)
			OP_LI: begin
				op1_d = '0;
				op2_d = {8'h00, front_inst[7:0]};
				res_d = op2_d;
			end
			OP_ADD: res_d = fwd_op1 + fwd_op2;
			OP_SUB: res_d = fwd_op1 - fwd_op2;
			OP_AND: res_d = fwd_op1 & fwd_op2;
			OP_OR:  res_d = fwd_op1 | fwd_op2;
			OP_XOR: res_d = fwd_op1 ^ fwd_op2;
			OP_MOV: res_d = fwd_op1;
			// NOP and unused codes write nothing
			default: writes_d = 1'b0;
		endcase
	end

	// Write port follows the execute registers
	assign wr_addr = exe_inst[11:8];
	assign wr_data = alu_res;

	//////////////////////////////
	// Execute registers
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_en    <= 1'b0;
			exe_pc   <= '0;
			exe_inst <= '0;
			alu_op1  <= '0;
			alu_op2  <= '0;
			alu_res  <= '0;
			alu_flag <= 1'b0;
		end else begin
			wr_en <= pop & writes_d;
			// Last executed instruction stays put once the queue drains
			if (pop) begin
				exe_pc   <= front_pc;
				exe_inst <= front_inst;
				alu_op1  <= op1_d;
				alu_op2  <= op2_d;
				alu_res  <= res_d;
				alu_flag <= (res_d == '0);
			end
		end
	end

endmodule

// File: hdl/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue import cpu_debug_pkg::*; #(
	parameter  int QUEUE_DEPTH = 8,
	localparam int PTR_W       = $clog2(QUEUE_DEPTH)
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push,
	input  reg_value_t       push_inst,
	input  logic             pop,
	output reg_value_t       front_inst,
	output reg_value_t       front_pc,
	output logic [PTR_W-1:0] front_ptr,
	output logic [PTR_W-1:0] tail_ptr,
	output logic             empty,
	output logic             full
);

	// Instruction and its pc stored side by side
	reg_value_t inst_mem [QUEUE_DEPTH];
	reg_value_t pc_mem   [QUEUE_DEPTH];

	// Pointers carry one extra wrap bit
	logic [PTR_W:0] front_q;
	logic [PTR_W:0] tail_q;
	reg_value_t     pc_cnt;

	logic push_ok;
	logic pop_ok;

	assign front_ptr = front_q[PTR_W-1:0];
	assign tail_ptr  = tail_q[PTR_W-1:0];

	assign empty = (front_q == tail_q);
	assign full  = (front_q[PTR_W-1:0] == tail_q[PTR_W-1:0]) &&
	               (front_q[PTR_W] != tail_q[PTR_W]);

	// Pushes while full are lost
	assign push_ok = push & ~full;
	assign pop_ok  = pop & ~empty;

	// Front entry reads as zero while the queue is empty
	assign front_inst = empty ? '0 : inst_mem[front_ptr];
	assign front_pc   = empty ? '0 : pc_mem[front_ptr];

	always_ff @(posedge clk) begin
		if (push_ok) begin
			inst_mem[tail_ptr] <= push_inst;
			pc_mem[tail_ptr]   <= pc_cnt;
		end
	end

	//////////////////////////////
	// Pointer and pc counters
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			front_q <= '0;
			tail_q  <= '0;
			pc_cnt  <= '0;
		end else begin
			if (push_ok) begin
				tail_q <= tail_q + 1'b1;
				pc_cnt <= pc_cnt + 1'b1;
			end
			if (pop_ok) begin
				front_q <= front_q + 1'b1;
			end
		end
	end

endmodule

// File: hdl/led_ctrl.sv
`timescale 1ns/10ps

module led_ctrl import cpu_debug_pkg::*; #(
	parameter  int QUEUE_DEPTH = 8,
	localparam int PTR_W       = $clog2(QUEUE_DEPTH)
) (
	input  logic [15:0]        sw,
	input  logic [PTR_W-1:0]   front_ptr,
	input  logic [PTR_W-1:0]   tail_ptr,
	input  reg_value_t         front_inst,
	input  reg_value_t         front_pc,
	input  reg_value_t         exe_pc,
	input  reg_value_t         exe_inst,
	input  reg_value_t         alu_op1,
	input  reg_value_t         alu_op2,
	input  reg_value_t         alu_res,
	input  logic               alu_flag,
	input  logic               wr_en,
	input  reg_addr_t          wr_addr,
	input  reg_value_t         wr_data,
	input  logic               hold,
	input  logic               empty,
	input  logic               full,
	input  logic               busy,
	input  logic [DEBUG_W-1:0] reg_debug,
	output logic [15:0]        led_data
);

	view_sel_t sel;
	reg_addr_t reg_idx;
	logic [7:0] front_ptr_w;
	logic [7:0] tail_ptr_w;

	assign sel = sw[15:8];

	// 0x3F shows register 0, counting down to 0x30
	assign reg_idx = reg_addr_t'(VIEW_REG_HI - sel);

	assign front_ptr_w = 8'(front_ptr);
	assign tail_ptr_w  = 8'(tail_ptr);

	always_comb begin
		case (sel) inside
			VIEW_STATUS: begin
				led_data = {hold, 1'b0, empty, 1'b0, full, 1'b0, busy, 1'b0,
				            wr_en, 7'b0};
			end
			VIEW_FRONT_PC:   led_data = front_pc;
			VIEW_FRONT_INST: led_data = front_inst;

			//////////////////////////////
			// Execute stage
			//////////////////////////////
			VIEW_EXE_PC:     led_data = exe_pc;
			VIEW_EXE_INST:   led_data = exe_inst;
			VIEW_EXE_CTRL: begin
				led_data = {wr_en, 3'b0, alu_flag, 3'b0, wr_addr, 4'b0};
			end
			VIEW_ALU_OP1:    led_data = alu_op1;
			VIEW_ALU_OP2:    led_data = alu_op2;
			VIEW_ALU_RES:    led_data = alu_res;
			VIEW_WB_DATA:    led_data = wr_data;

			// Register file
			[VIEW_REG_LO:VIEW_REG_HI]: begin
				led_data = reg_debug[reg_idx*DATA_W +: DATA_W];
			end

			// Queue
			VIEW_QUEUE_PTR:   led_data = {front_ptr_w, tail_ptr_w};
			VIEW_QUEUE_FRONT: led_data = front_inst;

			// Echo switches otherwise
			default: led_data = sw;
		endcase
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/10ps

module reg_file import cpu_debug_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  reg_addr_t          rd_addr1,
	input  reg_addr_t          rd_addr2,
	input  logic               wr_en,
	input  reg_addr_t          wr_addr,
	input  reg_value_t         wr_data,
	output reg_value_t         rd_data1,
	output reg_value_t         rd_data2,
	output logic [DEBUG_W-1:0] reg_debug
);

	reg_value_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Read ports see the committed values only
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

	// Flat copy for the LED views with register k at bits 16k+15:16k
	always_comb begin
		for (int k = 0; k < NUM_REGS; k++) begin
			reg_debug[k*DATA_W +: DATA_W] = regs[k];
		end
	end

endmodule

// File: sim.f
hdl/cpu_debug_pkg.sv
hdl/fetch_queue.sv
hdl/exec_stage.sv
hdl/reg_file.sv
hdl/led_ctrl.sv
hdl/cpu_debug_top.sv
sim/tb_cpu_debug.sv

// File: sim/tb_cpu_debug.sv
`timescale 1ns/10ps

module tb_cpu_debug import cpu_debug_pkg::*; #(
	parameter int QUEUE_DEPTH = 8
);

	localparam int CLK_HALF     = 20;
	localparam int IDLE_TIMEOUT = 200;

	logic        clk;
	logic        rst_n;
	logic [15:0] sw;
	logic        push;
	reg_value_t  push_inst;
	logic        hold;
	logic [15:0] led_data;
	logic        full;
	logic        busy;

	integer seed;

	// Reference model state
	reg_value_t m_regs [NUM_REGS];
	reg_value_t m_inst_q [$];
	reg_value_t m_pc_q [$];
	reg_value_t m_pc_cnt;
	int         m_pop_cnt;
	reg_value_t m_exe_pc;
	reg_value_t m_exe_inst;
	reg_value_t m_op1;
	reg_value_t m_op2;
	reg_value_t m_res;
	logic       m_flag;

	cpu_debug_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.sw        (sw),
		.push      (push),
		.push_inst (push_inst),
		.hold      (hold),
		.led_data  (led_data),
		.full      (full),
		.busy      (busy)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#CLK_HALF clk = ~clk;
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic reg_value_t alu_result(reg_value_t inst, reg_value_t a, reg_value_t b);
		case (opcode_t'(inst[15:12]))
			OP_LI:   return {8'h00, inst[7:0]};
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_MOV:  return a;
			default: return '0;
		endcase
	endfunction

	task automatic model_push(reg_value_t inst);
		// Full queue drops the push and keeps the pc
		if (m_inst_q.size() < QUEUE_DEPTH) begin
			m_inst_q.push_back(inst);
			m_pc_q.push_back(m_pc_cnt);
			m_pc_cnt = m_pc_cnt + 16'd1;
		end
	endtask

	task automatic model_pop();
		reg_value_t inst;
		reg_value_t a;
		reg_value_t b;
		inst = m_inst_q.pop_front();
		m_exe_pc = m_pc_q.pop_front();
		m_exe_inst = inst;
		a = m_regs[inst[7:4]];
		b = m_regs[inst[3:0]];
		if (opcode_t'(inst[15:12]) == OP_LI) begin
			a = '0;
			b = {8'h00, inst[7:0]};
		end
		m_op1 = a;
		m_op2 = b;
		m_res = alu_result(inst, a, b);
		m_flag = (m_res == '0);
		if (opcode_t'(inst[15:12]) != OP_NOP) begin
			m_regs[inst[11:8]] = m_res;
		end
		m_pop_cnt++;
	endtask

	task automatic drain_model();
		while (m_inst_q.size() > 0) begin
			model_pop();
		end
	endtask

	// LED view of a settled design
	function automatic reg_value_t expected_view(view_sel_t sel, logic [7:0] low);
		logic       empty_m;
		logic       full_m;
		reg_value_t front_inst_m;
		reg_value_t front_pc_m;
		logic [7:0] front_idx;
		logic [7:0] tail_idx;
		empty_m = (m_inst_q.size() == 0);
		full_m = (m_inst_q.size() == QUEUE_DEPTH);
		front_inst_m = empty_m ? '0 : m_inst_q[0];
		front_pc_m = empty_m ? '0 : m_pc_q[0];
		front_idx = 8'(m_pop_cnt % QUEUE_DEPTH);
		tail_idx = 8'(int'(m_pc_cnt) % QUEUE_DEPTH);
		if (sel >= VIEW_REG_LO && sel <= VIEW_REG_HI) begin
			return m_regs[int'(VIEW_REG_HI) - int'(sel)];
		end
		case (sel)
			VIEW_STATUS: begin
				return {hold, 1'b0, empty_m, 1'b0, full_m, 1'b0, !empty_m, 1'b0, 1'b0, 7'b0};
			end
			VIEW_FRONT_PC:    return front_pc_m;
			VIEW_FRONT_INST:  return front_inst_m;
			VIEW_EXE_PC:      return m_exe_pc;
			VIEW_EXE_INST:    return m_exe_inst;
			VIEW_EXE_CTRL:    return {1'b0, 3'b0, m_flag, 3'b0, m_exe_inst[11:8], 4'b0};
			VIEW_ALU_OP1:     return m_op1;
			VIEW_ALU_OP2:     return m_op2;
			VIEW_ALU_RES:     return m_res;
			VIEW_WB_DATA:     return m_res;
			VIEW_QUEUE_PTR:   return {front_idx, tail_idx};
			VIEW_QUEUE_FRONT: return front_inst_m;
			default:          return {sel, low};
		endcase
	endfunction

	//////////////////////////////
	// Checks and waits
	//////////////////////////////
	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "Testbench stopped at the first failure");
	endtask

	task automatic check_word(string what, reg_value_t got, reg_value_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_level(string what, logic got, logic exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_view(view_sel_t sel);
		logic [7:0] low;
		low = 8'($random(seed));
		@(negedge clk);
		sw = {sel, low};
		#(CLK_HALF / 2);
		check_word($sformatf("view %02h", sel), led_data, expected_view(sel, low));
	endtask

	task automatic check_registers();
		for (int k = 0; k < NUM_REGS; k++) begin
			check_view(view_sel_t'(int'(VIEW_REG_HI) - k));
		end
	endtask

	task automatic check_execute();
		check_view(VIEW_EXE_PC);
		check_view(VIEW_EXE_INST);
		check_view(VIEW_ALU_OP1);
		check_view(VIEW_ALU_OP2);
		check_view(VIEW_ALU_RES);
		check_view(VIEW_EXE_CTRL);
		check_view(VIEW_WB_DATA);
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (busy !== 1'b0) begin
			if (cycles == IDLE_TIMEOUT) begin
				$display("Timeout: busy stayed high for %0d cycles", IDLE_TIMEOUT);
				abort_run();
			end
			cycles++;
			@(negedge clk);
		end
		drain_model();
	endtask

	task automatic push_one(reg_value_t inst);
		@(negedge clk);
		// Without hold the waiting entry pops on the same edge as this push
		if (!hold) begin
			drain_model();
		end
		push = 1'b1;
		push_inst = inst;
		model_push(inst);
	endtask

	task automatic end_push();
		@(negedge clk);
		push = 1'b0;
	endtask

	function automatic reg_value_t random_alu();
		reg_value_t r;
		opcode_t    op;
		r = reg_value_t'($random(seed));
		op = opcode_t'(4'(2 + ($unsigned($random(seed)) % 6)));
		return {op, r[11:0]};
	endfunction

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		reg_value_t inst;
		reg_value_t prev;
		seed = 78062;
		rst_n = 1'b0;
		sw = '0;
		push = 1'b0;
		push_inst = '0;
		hold = 1'b0;
		for (int k = 0; k < NUM_REGS; k++) begin
			m_regs[k] = '0;
		end
		m_pc_cnt = '0;
		m_pop_cnt = 0;
		m_exe_pc = '0;
		m_exe_inst = '0;
		m_op1 = '0;
		m_op2 = '0;
		m_res = '0;
		m_flag = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Every selector after reset
		for (int s = 0; s < 256; s++) begin
			check_view(view_sel_t'(s));
		end
		check_level("full after reset", full, 1'b0);
		check_level("busy after reset", busy, 1'b0);

		// Load immediates, then dependent ALU traffic
		for (int k = 0; k < NUM_REGS; k++) begin
			push_one({OP_LI, reg_addr_t'(k), 8'($random(seed))});
		end
		prev = '0;
		for (int i = 0; i < 24; i++) begin
			inst = random_alu();
			if (i % 2 == 1) begin
				inst[7:4] = prev[11:8];
			end
			push_one(inst);
			prev = inst;
		end
		end_push();
		wait_idle();
		check_registers();
		check_execute();
		check_view(VIEW_STATUS);

		// Fill under hold, then one push too many
		@(negedge clk);
		hold = 1'b1;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			push_one(random_alu());
		end
		end_push();
		check_level("full after fill", full, 1'b1);
		push_one({OP_LI, 4'hF, 8'hEE});
		end_push();
		check_level("full after dropped push", full, 1'b1);
		check_level("busy under hold", busy, 1'b1);
		check_view(VIEW_QUEUE_PTR);
		check_view(VIEW_FRONT_PC);
		check_view(VIEW_FRONT_INST);
		check_view(VIEW_QUEUE_FRONT);
		check_view(VIEW_STATUS);

		// Release and drain
		@(negedge clk);
		hold = 1'b0;
		wait_idle();
		check_registers();
		check_execute();
		check_view(VIEW_QUEUE_PTR);
		check_view(VIEW_STATUS);
		check_level("full after drain", full, 1'b0);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
